// File: design/adc_cfg_pkg.sv
package adc_cfg_pkg;

    typedef logic [10:0] reg_addr_t;   // device register byte address
    typedef logic [8:0]  word_addr_t;  // host word address, reg address >> 2
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // 24-bit SPI frame, sent MSB first
    typedef struct packed {
        logic        rw;    // 1 read, 0 write
        logic [1:0]  rsvd;  // always zero
        logic [12:0] addr;  // top 2 bits zero
        byte_t       data;
    } spi_frame_t;

    // host write entry held in the command FIFO
    typedef struct packed {
        strb_t      strb;
        word_addr_t addr;
        word_t      data;
    } wr_cmd_t;

    localparam logic SPI_READ  = 1'b1;
    localparam logic SPI_WRITE = 1'b0;

    localparam reg_addr_t ADDR_CHIP_TYPE = 11'h004;
    localparam reg_addr_t ADDR_VENDOR_L  = 11'h00C;
    localparam reg_addr_t ADDR_VENDOR_H  = 11'h00D;
    localparam reg_addr_t ADDR_PLL_CTRL  = 11'h56F;

    localparam byte_t CHIP_TYPE_ID = 8'hC5;
    localparam byte_t VENDOR_ID_L  = 8'h56;
    localparam byte_t VENDOR_ID_H  = 8'h04;

    localparam int PLL_LOCK_BIT = 7;

endpackage

// File: design/adc_cmd_fifo.sv
`timescale 1ns/10ps

module adc_cmd_fifo import adc_cfg_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wvalid,
    input  word_addr_t waddr,
    input  word_t      wdata,
    input  strb_t      wstrb,
    input  logic       cmd_pop,
    output wr_cmd_t    cmd,
    output logic       cmd_empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    wr_cmd_t          mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;
    logic             pop;

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign cmd_empty = (count == '0);
    assign push      = wvalid && !full;
    assign pop       = cmd_pop && !cmd_empty;
    assign cmd       = mem[rd_ptr];  // head entry, shown without delay

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= '{strb: wstrb, addr: waddr, data: wdata};
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // host has no back-pressure, it must respect the depth
    a_no_push_full: assert property (@(posedge CLK) disable iff (RESET) wvalid |-> !full);
    a_no_pop_empty: assert property (@(posedge CLK) disable iff (RESET) cmd_pop |-> !cmd_empty);

endmodule

// File: design/adc_reg_mirror.sv
`timescale 1ns/10ps

module adc_reg_mirror import adc_cfg_pkg::*; #(
    parameter reg_addr_t SCAN_LAST = 11'h5C5
) (
    input  logic       CLK,
    input  logic       mirror_we,
    input  reg_addr_t  mirror_waddr,
    input  byte_t      mirror_wdata,
    input  word_addr_t raddr,
    output word_t      rdata
);

    localparam int WORDS = int'(SCAN_LAST >> 2) + 1;  // enough words for 0..SCAN_LAST

    byte_t [3:0] mem [WORDS];
    word_addr_t  wr_word;
    logic [1:0]  wr_lane;

    assign wr_word = mirror_waddr[10:2];
    assign wr_lane = mirror_waddr[1:0];

    // one byte lane per scanned register
    always_ff @(posedge CLK) begin
        if (mirror_we) begin
            mem[wr_word][wr_lane] <= mirror_wdata;
        end
    end

    always_ff @(posedge CLK) begin
        rdata <= mem[raddr];  // lane k = register 4*raddr+k
    end

    // the sequencer never writes past the scanned range
    a_waddr_range: assert property (@(posedge CLK)
        mirror_we |-> (mirror_waddr <= SCAN_LAST));

endmodule

// File: design/adc_spi_shifter.sv
`timescale 1ns/10ps

module adc_spi_shifter import adc_cfg_pkg::*; #(
    parameter int SCLK_HALF = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       frame_start,
    input  spi_frame_t tx_frame,
    output logic       spi_busy,
    output logic       frame_done,
    output byte_t      rx_byte,
    output logic       adc_csb,
    output logic       adc_sclk,
    output logic       adc_sdo,
    input  logic       adc_sdi
);

    localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       bit_cnt;
    logic [23:0]      tx_sr;
    logic             half_tick;

    assign half_tick = (div_cnt == DIV_W'(SCLK_HALF - 1));
    assign adc_sdo   = tx_sr[23];  // msb first

    always_ff @(posedge CLK) begin
        if (RESET) begin
            spi_busy   <= 1'b0;
            frame_done <= 1'b0;
            adc_csb    <= 1'b1;
            adc_sclk   <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
        end else begin
            frame_done <= 1'b0;
            if (frame_start) begin
                spi_busy <= 1'b1;
                adc_csb  <= 1'b0;
                adc_sclk <= 1'b0;
                div_cnt  <= '0;
                bit_cnt  <= '0;
            end else if (spi_busy) begin
                if (half_tick) begin
                    div_cnt  <= '0;
                    adc_sclk <= !adc_sclk;
                    if (adc_sclk) begin  // falling edge ends a bit
                        if (bit_cnt == 5'd23) begin
                            spi_busy   <= 1'b0;
                            adc_csb    <= 1'b1;
                            frame_done <= 1'b1;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    // sdo moves on falling sclk, sdi sampled on rising sclk
    always_ff @(posedge CLK) begin
        if (frame_start) begin
            tx_sr <= tx_frame;
        end else if (spi_busy && half_tick) begin
            if (adc_sclk) begin
                tx_sr <= {tx_sr[22:0], 1'b0};
            end else begin
                rx_byte <= {rx_byte[6:0], adc_sdi};  // last 8 samples = read data
            end
        end
    end

    a_done_timing: assert property (@(posedge CLK) disable iff (RESET)
        frame_start |-> ##(48 * SCLK_HALF + 1) frame_done);

endmodule

// File: design/adc_cfg_sequencer.sv
`timescale 1ns/10ps

module adc_cfg_sequencer import adc_cfg_pkg::*; #(
    parameter reg_addr_t SCAN_LAST = 11'h5C5
) (
    input  logic       CLK,
    input  logic       RESET,
    input  word_t      scan_interval,
    input  wr_cmd_t    cmd,
    input  logic       cmd_empty,
    output logic       cmd_pop,
    output logic       frame_start,
    output spi_frame_t tx_frame,
    input  logic       frame_done,
    input  byte_t      rx_byte,
    input  logic       spi_busy,
    output logic       mirror_we,
    output reg_addr_t  mirror_waddr,
    output byte_t      mirror_wdata,
    output logic       adc_good,
    output logic       adc_bad
);

    typedef enum logic [2:0] {
        st_idle,
        st_scan_send,
        st_scan_wait,
        st_cmd_load,
        st_lane_check,
        st_lane_send,
        st_lane_wait
    } state_t;

    state_t     state;
    word_t      scan_timer;
    logic       scan_due;
    logic       scanning;
    reg_addr_t  scan_addr;
    logic       scan_end;
    strb_t      lane_strb;
    word_addr_t lane_waddr;
    word_t      lane_data;
    logic [1:0] lane;
    byte_t      chip_type;
    byte_t      vendor_l;
    byte_t      vendor_h;
    byte_t      pll_ctrl;
    byte_t      chip_type_nx;
    byte_t      vendor_l_nx;
    byte_t      vendor_h_nx;
    byte_t      pll_ctrl_nx;
    logic       status_ok;

    assign scan_due     = (scan_timer == scan_interval - 32'd1);
    assign scanning     = (state == st_scan_send) || (state == st_scan_wait);
    assign cmd_pop      = (state == st_cmd_load);  // head latched and popped on same edge
    assign frame_start  = (state == st_scan_send) || (state == st_lane_send);
    assign mirror_we    = (state == st_scan_wait) && frame_done;
    assign mirror_waddr = scan_addr;
    assign mirror_wdata = rx_byte;
    assign scan_end     = mirror_we && (scan_addr == SCAN_LAST);

    always_comb begin
        tx_frame = '0;
        if (state == st_scan_send) begin
            tx_frame.rw   = SPI_READ;
            tx_frame.addr = {2'b00, scan_addr};
        end else begin
            tx_frame.rw   = SPI_WRITE;
            tx_frame.addr = {2'b00, lane_waddr, lane};  // word address * 4 + lane
            tx_frame.data = lane_data[8*lane +: 8];
        end
    end

    // idle counter, held while scanning
    always_ff @(posedge CLK) begin
        if (RESET) begin
            scan_timer <= '0;
        end else if (state == st_idle && scan_due) begin
            scan_timer <= '0;
        end else if (!scanning && !scan_due) begin
            scan_timer <= scan_timer + 32'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= st_idle;
            scan_addr <= '0;
            lane      <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (scan_due) begin
                        scan_addr <= '0;
                        state     <= st_scan_send;
                    end else if (!cmd_empty) begin
                        state <= st_cmd_load;
                    end
                end
                st_scan_send: state <= st_scan_wait;
                st_scan_wait: begin
                    if (frame_done) begin
                        if (scan_addr == SCAN_LAST) begin
                            state <= st_idle;
                        end else begin
                            scan_addr <= scan_addr + 1'b1;
                            state     <= st_scan_send;
                        end
                    end
                end
                st_cmd_load: begin
                    lane  <= '0;
                    state <= st_lane_check;
                end
                st_lane_check: begin
                    if (lane_strb[lane]) begin
                        state <= st_lane_send;
                    end else if (lane == 2'd3) begin
                        state <= st_idle;
                    end else begin
                        lane <= lane + 1'b1;
                    end
                end
                st_lane_send: state <= st_lane_wait;
                st_lane_wait: begin
                    if (frame_done) begin
                        if (lane == 2'd3) begin
                            state <= st_idle;
                        end else begin
                            lane  <= lane + 1'b1;
                            state <= st_lane_check;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (state == st_cmd_load) begin
            lane_strb  <= cmd.strb;
            lane_waddr <= cmd.addr;
            lane_data  <= cmd.data;
        end
    end

    // id bytes as they will be after this edge, so the last frame counts too
    always_comb begin
        chip_type_nx = chip_type;
        vendor_l_nx  = vendor_l;
        vendor_h_nx  = vendor_h;
        pll_ctrl_nx  = pll_ctrl;
        if (mirror_we) begin
            case (scan_addr)
                ADDR_CHIP_TYPE: chip_type_nx = rx_byte;
                ADDR_VENDOR_L:  vendor_l_nx  = rx_byte;
                ADDR_VENDOR_H:  vendor_h_nx  = rx_byte;
                ADDR_PLL_CTRL:  pll_ctrl_nx  = rx_byte;
                default:        ;
            endcase
        end
    end

    assign status_ok = (chip_type_nx == CHIP_TYPE_ID) && (vendor_l_nx == VENDOR_ID_L) &&
                       (vendor_h_nx == VENDOR_ID_H) && pll_ctrl_nx[PLL_LOCK_BIT];

    always_ff @(posedge CLK) begin
        chip_type <= chip_type_nx;
        vendor_l  <= vendor_l_nx;
        vendor_h  <= vendor_h_nx;
        pll_ctrl  <= pll_ctrl_nx;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            adc_good <= 1'b0;
            adc_bad  <= 1'b0;
        end else if (scan_end) begin
            adc_good <= status_ok;
            adc_bad  <= !status_ok;
        end
    end

    // frames only go out to an idle shifter
    a_start_idle: assert property (@(posedge CLK) disable iff (RESET)
        frame_start |-> !spi_busy);

endmodule

// File: design/adc_cfg_top.sv
`timescale 1ns/10ps

module adc_cfg_top import adc_cfg_pkg::*; #(
    parameter int        FIFO_DEPTH = 16,
    parameter reg_addr_t SCAN_LAST  = 11'h5C5,
    parameter int        SCLK_HALF  = 2
) (
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wvalid,
    input  word_addr_t waddr,
    input  word_t      wdata,
    input  strb_t      wstrb,
    input  word_addr_t raddr,
    output word_t      rdata,
    input  word_t      scan_interval,
    output logic       adc_good,
    output logic       adc_bad,
    output logic       adc_csb,
    output logic       adc_sclk,
    output logic       adc_sdo,
    input  logic       adc_sdi
);

    wr_cmd_t    cmd;
    logic       cmd_empty;
    logic       cmd_pop;
    logic       frame_start;
    spi_frame_t tx_frame;
    logic       spi_busy;
    logic       frame_done;
    byte_t      rx_byte;
    logic       mirror_we;
    reg_addr_t  mirror_waddr;
    byte_t      mirror_wdata;

    adc_cmd_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo_i (
        .CLK(CLK), .RESET(RESET),
        .wvalid(wvalid), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
        .cmd_pop(cmd_pop), .cmd(cmd), .cmd_empty(cmd_empty)
    );

    adc_cfg_sequencer #(.SCAN_LAST(SCAN_LAST)) sequencer_i (
        .CLK(CLK), .RESET(RESET), .scan_interval(scan_interval),
        .cmd(cmd), .cmd_empty(cmd_empty), .cmd_pop(cmd_pop),
        .frame_start(frame_start), .tx_frame(tx_frame), .frame_done(frame_done),
        .rx_byte(rx_byte), .spi_busy(spi_busy),
        .mirror_we(mirror_we), .mirror_waddr(mirror_waddr), .mirror_wdata(mirror_wdata),
        .adc_good(adc_good), .adc_bad(adc_bad)
    );

    adc_reg_mirror #(.SCAN_LAST(SCAN_LAST)) reg_mirror_i (
        .CLK(CLK), .mirror_we(mirror_we), .mirror_waddr(mirror_waddr),
        .mirror_wdata(mirror_wdata), .raddr(raddr), .rdata(rdata)
    );

    adc_spi_shifter #(.SCLK_HALF(SCLK_HALF)) spi_shifter_i (
        .CLK(CLK), .RESET(RESET),
        .frame_start(frame_start), .tx_frame(tx_frame), .spi_busy(spi_busy),
        .frame_done(frame_done), .rx_byte(rx_byte),
        .adc_csb(adc_csb), .adc_sclk(adc_sclk), .adc_sdo(adc_sdo), .adc_sdi(adc_sdi)
    );

endmodule

// File: test/adc_spi_model.sv
`timescale 1ns/10ps

module adc_spi_model (
    input  logic adc_csb,
    input  logic adc_sclk,
    input  logic adc_sdo,
    output logic adc_sdi
);

    logic [7:0]  regs [2048];  // device register space
    logic [23:0] sr;
    logic [4:0]  cnt;
    logic        rd;
    logic [10:0] rd_addr;
    int          rd_count = 0;  // completed read frames
    int          wr_count = 0;  // completed write frames
    int          seed;

    initial begin
        seed    = 91190;
        adc_sdi = 1'b0;
        rd      = 1'b0;
        rd_addr = '0;
        sr      = '0;
        cnt     = '0;
        for (int i = 0; i < 2048; i++) begin
            regs[i] = 8'($random(seed));
        end
    end

    // frame bits shift in on rising sclk
    always @(posedge adc_sclk or posedge adc_csb) begin
        if (adc_csb) begin
            cnt = '0;
        end else begin
            sr = {sr[22:0], adc_sdo};
            if (cnt == 5'd15) begin  // rw and address complete
                rd      = sr[15];
                rd_addr = sr[10:0];
            end
            if (cnt == 5'd23) begin
                if (rd) begin
                    rd_count++;
                end else begin
                    regs[sr[18:8]] = sr[7:0];
                    wr_count++;
                end
            end
            cnt = cnt + 5'd1;
        end
    end

    // read data goes out after the falling edge, msb first
    always @(negedge adc_sclk) begin
        if (!adc_csb && rd && cnt >= 5'd16 && cnt <= 5'd23) begin
            adc_sdi = regs[rd_addr][3'(5'd23 - cnt)];
        end
    end

endmodule

// File: test/adc_cfg_tb.sv
`timescale 1ns/10ps

module adc_cfg_tb import adc_cfg_pkg::*; ();

    localparam reg_addr_t SCAN_LAST     = 11'h57F;
    localparam int        SCLK_HALF     = 2;
    localparam int        N_TESTS       = 6;
    localparam int        SCAN_CYCLES   = (int'(SCAN_LAST) + 1) * (48 * SCLK_HALF + 4);
    localparam int        TIMEOUT_LIMIT = N_TESTS * 2 * SCAN_CYCLES + SCAN_CYCLES;

    logic       CLK;
    logic       RESET;
    logic       wvalid;
    word_addr_t waddr;
    word_t      wdata;
    strb_t      wstrb;
    word_addr_t raddr;
    word_t      rdata;
    word_t      scan_interval;
    logic       adc_good;
    logic       adc_bad;
    logic       adc_csb;
    logic       adc_sclk;
    logic       adc_sdo;
    logic       adc_sdi;

    int errors = 0;
    int passed = 0;
    int failed = 0;
    int cycles = 0;
    int seed   = 91190;

    adc_cfg_top #(.SCAN_LAST(SCAN_LAST), .SCLK_HALF(SCLK_HALF)) dut_i (
        .CLK(CLK), .RESET(RESET),
        .wvalid(wvalid), .waddr(waddr), .wdata(wdata), .wstrb(wstrb),
        .raddr(raddr), .rdata(rdata), .scan_interval(scan_interval),
        .adc_good(adc_good), .adc_bad(adc_bad),
        .adc_csb(adc_csb), .adc_sclk(adc_sclk), .adc_sdo(adc_sdo), .adc_sdi(adc_sdi)
    );

    adc_spi_model model_i (
        .adc_csb(adc_csb), .adc_sclk(adc_sclk), .adc_sdo(adc_sdo), .adc_sdi(adc_sdi)
    );

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= TIMEOUT_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            $display("%s: ok", name);
            passed++;
        end else begin
            $display("%s: %0d mismatches", name, errors - err0);
            failed++;
        end
    endtask

    // little-endian packing, byte k = register 4*w+k
    function automatic word_t model_word(input word_addr_t w);
        int b;
        b = 4 * int'(w);
        return {model_i.regs[b + 3], model_i.regs[b + 2], model_i.regs[b + 1], model_i.regs[b]};
    endfunction

    task automatic host_write(input word_addr_t a, input word_t d, input strb_t s);
        wvalid = 1'b1;
        waddr  = a;
        wdata  = d;
        wstrb  = s;
        @(negedge CLK);
        wvalid = 1'b0;
    endtask

    task automatic write_reg_byte(input reg_addr_t a, input byte_t v);
        host_write(a[10:2], word_t'(v) << (8 * a[1:0]), strb_t'(1) << a[1:0]);
    endtask

    task automatic wait_writes(input int target);
        while (model_i.wr_count != target) begin
            @(negedge CLK);
        end
    endtask

    // one full scan: a read of register 0, then of SCAN_LAST
    task automatic wait_scan_end;
        int seen;
        int phase;
        seen  = model_i.rd_count;
        phase = 0;
        while (phase < 2) begin
            @(negedge CLK);
            if (model_i.rd_count != seen) begin
                seen = model_i.rd_count;
                if (phase == 0 && model_i.rd_addr == 11'd0) begin
                    phase = 1;
                end else if (phase == 1 && model_i.rd_addr == SCAN_LAST) begin
                    phase = 2;
                end
            end
        end
        repeat (2 * SCLK_HALF + 2) @(negedge CLK);  // frame_done, then status
    endtask

    task automatic test_reset_state;
        int err0;
        err0 = errors;
        check_value("adc_csb", adc_csb, 1);
        check_value("adc_sclk", adc_sclk, 0);
        check_value("adc_good", adc_good, 0);
        check_value("adc_bad", adc_bad, 0);
        report_test("reset state", err0);
    endtask

    task automatic test_strobe_write;
        int    err0;
        int    base;
        word_t data;
        byte_t old [4];
        int    k;
        err0 = errors;
        base = model_i.wr_count;
        data = $random(seed);
        for (k = 0; k < 4; k++) begin
            old[k] = model_i.regs[20 + k];
        end
        host_write(9'd5, data, 4'b1010);
        wait_writes(base + 2);
        check_value("model reg 20", model_i.regs[20], old[0]);
        check_value("model reg 21", model_i.regs[21], data[15:8]);
        check_value("model reg 22", model_i.regs[22], old[2]);
        check_value("model reg 23", model_i.regs[23], data[31:24]);
        report_test("byte-strobe write", err0);
    endtask

    task automatic test_mirror_readback;
        int err0;
        int w;
        err0 = errors;
        wait_scan_end();
        for (w = 0; w <= int'(SCAN_LAST >> 2); w++) begin
            raddr = word_addr_t'(w);
            @(negedge CLK);  // registered read
            check_value($sformatf("rdata at raddr 0x%0h", w), rdata, model_word(raddr));
        end
        report_test("mirror readback", err0);
    endtask

    task automatic test_good_status;
        int err0;
        int base;
        err0 = errors;
        base = model_i.wr_count;
        write_reg_byte(ADDR_CHIP_TYPE, CHIP_TYPE_ID);
        write_reg_byte(ADDR_VENDOR_L, VENDOR_ID_L);
        write_reg_byte(ADDR_VENDOR_H, VENDOR_ID_H);
        write_reg_byte(ADDR_PLL_CTRL, 8'h91);  // lock bit set
        wait_writes(base + 4);
        wait_scan_end();
        check_value("adc_good", adc_good, 1);
        check_value("adc_bad", adc_bad, 0);
        report_test("good status", err0);
    endtask

    task automatic test_bad_id;
        int err0;
        int base;
        err0 = errors;
        base = model_i.wr_count;
        write_reg_byte(ADDR_VENDOR_L, 8'h57);
        wait_writes(base + 1);
        wait_scan_end();
        check_value("adc_good", adc_good, 0);
        check_value("adc_bad", adc_bad, 1);
        report_test("bad status from id", err0);
    endtask

    task automatic test_bad_pll;
        int         err0;
        int         base;
        word_t      d [4];
        word_addr_t wa [4];
        int         i;
        err0  = errors;
        base  = model_i.wr_count;
        wa[0] = 9'h100;
        wa[1] = 9'h101;
        wa[2] = 9'h102;
        wa[3] = 9'h100;  // overwrite, last one must win
        for (i = 0; i < 4; i++) begin
            d[i] = $random(seed);
        end
        write_reg_byte(ADDR_VENDOR_L, VENDOR_ID_L);
        write_reg_byte(ADDR_PLL_CTRL, 8'h11);  // lock bit clear
        for (i = 0; i < 4; i++) begin
            host_write(wa[i], d[i], 4'hF);
        end
        wait_writes(base + 18);
        check_value("model word 0x100", model_word(9'h100), d[3]);
        check_value("model word 0x101", model_word(9'h101), d[1]);
        check_value("model word 0x102", model_word(9'h102), d[2]);
        wait_scan_end();
        check_value("adc_good", adc_good, 0);
        check_value("adc_bad", adc_bad, 1);
        report_test("bad status from pll", err0);
    endtask

    initial begin
        RESET         = 1'b1;
        wvalid        = 1'b0;
        waddr         = '0;
        wdata         = '0;
        wstrb         = '0;
        raddr         = '0;
        scan_interval = 32'd200;
        repeat (2) @(negedge CLK);
        RESET = 1'b0;
        test_reset_state();
        test_strobe_write();
        test_mirror_readback();
        test_good_status();
        test_bad_id();
        test_bad_pll();
        $display("summary: %0d tests, %0d ok, %0d with mismatches, %0d mismatches in all",
                 N_TESTS, passed, failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: adc_cfg_top.f
design/adc_cfg_pkg.sv
design/adc_cmd_fifo.sv
design/adc_reg_mirror.sv
design/adc_spi_shifter.sv
design/adc_cfg_sequencer.sv
design/adc_cfg_top.sv
test/adc_spi_model.sv
test/adc_cfg_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module adc_cfg_tb \
    -f adc_cfg_top.f -o adc_cfg_sim \
    && ./obj_dir/adc_cfg_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "all tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
